//--- all.f
+incdir+rtl
rtl/ddr_data_pkg.sv
rtl/ddr_ctrl_pkg.sv
rtl/ddio_out_soft.sv
rtl/ddr_write_burst.sv
rtl/ddr_write_path.sv
verification/ddr_clk_gen.sv
verification/ddr_write_path_tb.sv

//--- Bender.yml
package:
  name: ddr_write_path

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ddr_data_pkg.sv
      - rtl/ddr_ctrl_pkg.sv
      - rtl/ddio_out_soft.sv
      - rtl/ddr_write_burst.sv
      - rtl/ddr_write_path.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/ddr_clk_gen.sv
      - verification/ddr_write_path_tb.sv

//--- verification/ddr_write_path_tb.sv
/*
 * Testbench for the DDR write data path.
 * Random write strobes are driven on falling edges. A cycle-based model
 * predicts accepts, drops and the beats on every pin phase. The pins are
 * sampled 10 ns into each high phase and each low phase.
 */
`timescale 1ns/1ps
`include "ddr_out_config.svh"

module ddr_write_path_tb
	import ddr_ctrl_pkg::*;
();

	localparam int NUM_CMDS     = 300;
	localparam int CYCLE_LIMIT  = 4 * NUM_CMDS + 50;
	localparam int RESET_LIMIT  = 20;
	localparam int DRAIN_LIMIT  = 8;
	localparam int IDLE_CYCLES  = 4;
	localparam int WATCHDOG_NS  = 100000;
	localparam int SAMPLE_NS    = 10;

	// one expected clock of pin activity, rise and fall beat
	typedef struct packed {
		int                       edge_idx;
		logic [`DDR_DQ_WIDTH-1:0] rise_dq;
		logic [`DDR_DQ_WIDTH-1:0] fall_dq;
		logic [`DDR_DM_WIDTH-1:0] rise_dm;
		logic [`DDR_DM_WIDTH-1:0] fall_dm;
	} exp_cycle_t;

	logic                     clk;
	logic                     dr_reset_n;
	logic                     cmd_valid;
	wr_cmd_t                  cmd;
	logic [`DDR_DQ_WIDTH-1:0] dq_out;
	logic [`DDR_DM_WIDTH-1:0] dm_out;
	logic                     dqs_out;
	logic                     oe_out;
	logic                     cmd_drop;

	// model state
	exp_cycle_t exp_q[$];
	logic       drv_valid;
	wr_cmd_t    drv_cmd;
	logic       exp_drop;
	int         edge_count;
	int         last_accept_edge;
	int         strobes_sent;
	int         gap_left;
	int         n_accepted;
	int         n_dropped;
	int         n_chained;
	int         seed_ret;

	ddr_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) i_ddr_clk_gen (
		.clk        (clk),
		.dr_reset_n (dr_reset_n)
	);

	ddr_write_path i_ddr_write_path (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.dq_out     (dq_out),
		.dm_out     (dm_out),
		.dqs_out    (dqs_out),
		.oe_out     (oe_out),
		.cmd_drop   (cmd_drop)
	);

	// ****************************************
	// reporting
	// ****************************************

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_pin(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			abort_run($sformatf("FAIL time=%0t signal=%s expected=0x%0h actual=0x%0h",
				$time, name, expected, actual));
		end
	endtask

	// ****************************************
	// reference model
	// ****************************************

	// dm of beat k follows the opcode rule
	function automatic logic [`DDR_DM_WIDTH-1:0] expected_dm(input wr_cmd_t c, input int k);
		if (c.op == OP_WRITE_MASKED) begin
			return c.mask[k];
		end
		return '0;
	endfunction

	// strobe sampled at this edge, accepted unless the previous accept was one edge ago
	task automatic apply_edge_to_model();
		exp_cycle_t rec;
		logic       accepted;
		accepted = drv_valid && (edge_count >= last_accept_edge + 2);
		exp_drop = drv_valid && !accepted;
		if (exp_drop) begin
			n_dropped++;
		end
		if (accepted) begin
			if (edge_count == last_accept_edge + 2) begin
				n_chained++;
			end
			last_accept_edge = edge_count;
			n_accepted++;
			// beats 0/1 after edge N+2, beats 2/3 after edge N+3
			for (int h = 0; h < 2; h++) begin
				rec.edge_idx = edge_count + 2 + h;
				rec.rise_dq  = drv_cmd.data[2 * h];
				rec.fall_dq  = drv_cmd.data[2 * h + 1];
				rec.rise_dm  = expected_dm(drv_cmd, 2 * h);
				rec.fall_dm  = expected_dm(drv_cmd, 2 * h + 1);
				exp_q.push_back(rec);
			end
		end
	endtask

	// ****************************************
	// pin checks
	// ****************************************

	// high phase carries the rise beat, dqs high while oe is up
	task automatic check_rise_phase();
		check_pin("cmd_drop", 32'(exp_drop), 32'(cmd_drop));
		if (exp_q.size() > 0 && exp_q[0].edge_idx == edge_count) begin
			check_pin("dq_out", 32'(exp_q[0].rise_dq), 32'(dq_out));
			check_pin("dm_out", 32'(exp_q[0].rise_dm), 32'(dm_out));
			check_pin("dqs_out", 32'd1, 32'(dqs_out));
			check_pin("oe_out", 32'd1, 32'(oe_out));
		end else begin
			check_pin("dq_out", 32'd0, 32'(dq_out));
			check_pin("dm_out", 32'd0, 32'(dm_out));
			check_pin("dqs_out", 32'd0, 32'(dqs_out));
			check_pin("oe_out", 32'd0, 32'(oe_out));
		end
	endtask

	// low phase carries the fall beat and retires the cycle
	task automatic check_fall_phase();
		exp_cycle_t cur;
		check_pin("cmd_drop", 32'(exp_drop), 32'(cmd_drop));
		if (exp_q.size() > 0 && exp_q[0].edge_idx == edge_count) begin
			cur = exp_q.pop_front();
			check_pin("dq_out", 32'(cur.fall_dq), 32'(dq_out));
			check_pin("dm_out", 32'(cur.fall_dm), 32'(dm_out));
			check_pin("dqs_out", 32'd0, 32'(dqs_out));
			check_pin("oe_out", 32'd1, 32'(oe_out));
		end else begin
			check_pin("dq_out", 32'd0, 32'(dq_out));
			check_pin("dm_out", 32'd0, 32'(dm_out));
			check_pin("dqs_out", 32'd0, 32'(dqs_out));
			check_pin("oe_out", 32'd0, 32'(oe_out));
		end
	endtask

	// ****************************************
	// stimulus
	// ****************************************

	// payload is random every cycle, only the strobe makes it count
	// gap 0 hits the busy cycle, gap 1 chains the next burst
	task automatic drive_next_inputs();
		wr_cmd_t     c;
		logic [31:0] rnd;
		rnd    = $urandom();
		c.op   = wr_op_e'(rnd[31]);
		c.mask = rnd[`DDR_BURST_LEN*`DDR_DM_WIDTH-1:0];
		c.data = $urandom();
		cmd    = c;
		if (strobes_sent < NUM_CMDS && gap_left == 0) begin
			cmd_valid = 1'b1;
			strobes_sent++;
			gap_left = $urandom_range(3, 0);
		end else begin
			cmd_valid = 1'b0;
			if (gap_left > 0) begin
				gap_left--;
			end
		end
		drv_valid = cmd_valid;
		drv_cmd   = c;
	endtask

	// one clock: model update, high-phase check, drive, low-phase check
	task automatic run_cycle();
		@(posedge clk);
		edge_count++;
		apply_edge_to_model();
		#(SAMPLE_NS);
		check_rise_phase();
		@(negedge clk);
		drive_next_inputs();
		#(SAMPLE_NS);
		check_fall_phase();
	endtask

	// ****************************************
	// run control
	// ****************************************

	initial begin
		int n;
		cmd_valid        = 1'b0;
		cmd              = '0;
		drv_valid        = 1'b0;
		drv_cmd          = '0;
		exp_drop         = 1'b0;
		edge_count       = 0;
		last_accept_edge = -10;
		strobes_sent     = 0;
		gap_left         = 3;
		n_accepted       = 0;
		n_dropped        = 0;
		n_chained        = 0;
		seed_ret         = $urandom(32'hecaee879);

		// pins stay low through reset
		n = 0;
		while (dr_reset_n !== 1'b1 && n < RESET_LIMIT) begin
			@(posedge clk);
			#(SAMPLE_NS);
			check_pin("dq_out", 32'd0, 32'(dq_out));
			check_pin("dm_out", 32'd0, 32'(dm_out));
			check_pin("dqs_out", 32'd0, 32'(dqs_out));
			check_pin("oe_out", 32'd0, 32'(oe_out));
			check_pin("cmd_drop", 32'd0, 32'(cmd_drop));
			n++;
		end
		assert (dr_reset_n === 1'b1) else abort_run("reset was never released");

		n = 0;
		while (strobes_sent < NUM_CMDS && n < CYCLE_LIMIT) begin
			run_cycle();
			n++;
		end
		assert (strobes_sent == NUM_CMDS) else abort_run("stimulus did not complete in time");

		// last bursts leave the pipeline
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			run_cycle();
			n++;
		end
		assert (exp_q.size() == 0) else abort_run("expected bursts never reached the pins");

		// idle pins after the traffic
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			run_cycle();
		end
		// the final strobe is only modeled at the edge after it was driven
		assert (exp_q.size() == 0) else abort_run("expected bursts were left after the idle cycles");

		$display("strobes %0d accepted %0d dropped %0d chained %0d",
			strobes_sent, n_accepted, n_dropped, n_chained);
		if (n_dropped > 0 && n_chained > 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("random gaps never produced both a drop and a chained burst");
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	// hard limit on the whole run
	initial begin
		int elapsed;
		elapsed = 0;
		while (elapsed < WATCHDOG_NS) begin
			#1000;
			elapsed += 1000;
		end
		$display("timeout: the run did not finish within the time limit");
		$display("Simulation FAILED");
		$fatal(1);
	end

endmodule

//--- verification/ddr_clk_gen.sv
/*
 * Clock and reset source for the DDR write path testbench.
 * clk starts low with a 40 ns period. dr_reset_n is held low for the
 * first 8 rising edges and then released for the rest of the run.
 */
`timescale 1ns/1ps

module ddr_clk_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic dr_reset_n
);

	// free-running clock, first rising edge at half a period
	initial begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

	// release lands on a falling edge, away from the sampling edge
	initial begin
		dr_reset_n = 1'b0;
		#(PERIOD_NS * RESET_CYCLES);
		dr_reset_n = 1'b1;
	end

endmodule

//--- rtl/ddr_write_path.sv
/*
 * Top level of the DDR write data path.
 * The burst sequencer feeds one DDR output cell for dq and one for the
 * oe/dqs/dm control group. For a strobe at edge N, beat 0 is on dq_out in
 * the high phase after edge N+2 and oe_out stays high for two cycles.
 */
`timescale 1ns/1ps
`include "ddr_out_config.svh"

module ddr_write_path
	import ddr_data_pkg::*;
	import ddr_ctrl_pkg::*;
(
	input  logic                     clk,
	input  logic                     dr_reset_n,
	input  logic                     cmd_valid,
	input  wr_cmd_t                  cmd,
	output logic [`DDR_DQ_WIDTH-1:0] dq_out,
	output logic [`DDR_DM_WIDTH-1:0] dm_out,
	output logic                     dqs_out,
	output logic                     oe_out,
	output logic                     cmd_drop
);

	dq_pair_t  dq_pair;
	ctl_pair_t ctl_pair;
	// control pins of the current phase
	ctl_beat_t ctl_pin;

	ddr_write_burst i_ddr_write_burst (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.dq_pair    (dq_pair),
		.ctl_pair   (ctl_pair),
		.cmd_drop   (cmd_drop)
	);

	// data lanes
	ddio_out_soft #(.DATA_WIDTH(`DDR_DQ_WIDTH)) i_ddio_dq (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.pair_in    (dq_pair),
		.pin_out    (dq_out)
	);

	// oe, dqs and dm share one cell so they stay aligned with dq
	ddio_out_soft #(.DATA_WIDTH(CTL_WIDTH)) i_ddio_ctl (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.pair_in    (ctl_pair),
		.pin_out    (ctl_pin)
	);

	assign oe_out  = ctl_pin.oe;
	assign dqs_out = ctl_pin.dqs;
	assign dm_out  = ctl_pin.dm;

endmodule

//--- rtl/ddr_write_burst.sv
/*
 * Write burst sequencer.
 * An accepted command strobe is followed by two registered cycles of
 * dq/control pairs: beats 0 and 1, then beats 2 and 3. A strobe that hits
 * a busy sequencer is dropped and flagged on cmd_drop one cycle later.
 * The last burst cycle accepts a new command, so bursts can run back to back.
 */
`timescale 1ns/1ps
`include "ddr_out_config.svh"

module ddr_write_burst
	import ddr_data_pkg::*;
	import ddr_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      dr_reset_n,
	input  logic      cmd_valid,
	input  wr_cmd_t   cmd,
	output dq_pair_t  dq_pair,
	output ctl_pair_t ctl_pair,
	output logic      cmd_drop
);

	localparam int BEAT_IDX_W = $clog2(`DDR_BURST_LEN);

	burst_state_e          state;
	burst_state_e          state_nxt;
	wr_cmd_t               cmd_q;
	logic                  accept;
	logic                  emit;
	logic [BEAT_IDX_W-1:0] beat_lo;
	logic [BEAT_IDX_W-1:0] beat_hi;
	dq_pair_t              dq_nxt;
	ctl_pair_t             ctl_nxt;

	// dm for one beat, only masked writes use the mask
	function automatic logic [`DDR_DM_WIDTH-1:0] beat_dm(
		input wr_cmd_t               c,
		input logic [BEAT_IDX_W-1:0] k
	);
		beat_dm = (c.op == OP_WRITE_MASKED) ? c.mask[k] : '0;
	endfunction

	// ****************************************
	// command acceptance
	// ****************************************

	// only ST_FIRST is busy, ST_SECOND is the last burst cycle
	assign accept = cmd_valid && (state != ST_FIRST);

	always_comb begin
		state_nxt = ST_IDLE;
		case (state)
			ST_FIRST: state_nxt = ST_SECOND;
			default:  state_nxt = accept ? ST_FIRST : ST_IDLE;
		endcase
	end

	// payload latch
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			cmd_q <= '0;
		end else if (accept) begin
			cmd_q <= cmd;
		end
	end

	// ****************************************
	// pair generation
	// ****************************************

	assign emit    = (state == ST_FIRST) || (state == ST_SECOND);
	// first half sends beats 0/1, second half beats 2/3
	assign beat_lo = (state == ST_SECOND) ? BEAT_IDX_W'(PAIR_BEATS) : '0;
	assign beat_hi = beat_lo + 1'b1;

	always_comb begin
		dq_nxt  = '0;
		ctl_nxt = '0;
		if (emit) begin
			dq_nxt.rise      = cmd_q.data[beat_lo];
			dq_nxt.fall      = cmd_q.data[beat_hi];
			// dqs toggles once per clock, high with the rise beat
			ctl_nxt.rise.oe  = 1'b1;
			ctl_nxt.rise.dqs = 1'b1;
			ctl_nxt.rise.dm  = beat_dm(cmd_q, beat_lo);
			ctl_nxt.fall.oe  = 1'b1;
			ctl_nxt.fall.dqs = 1'b0;
			ctl_nxt.fall.dm  = beat_dm(cmd_q, beat_hi);
		end
	end

	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			state    <= ST_IDLE;
			dq_pair  <= '0;
			ctl_pair <= '0;
			cmd_drop <= 1'b0;
		end else begin
			state    <= state_nxt;
			dq_pair  <= dq_nxt;
			ctl_pair <= ctl_nxt;
			cmd_drop <= cmd_valid && !accept;
		end
	end

	// ****************************************
	// checks
	// ****************************************

	a_second_follows_first: assert property (
		@(posedge clk) disable iff (!dr_reset_n)
		(state == ST_FIRST) |=> (state == ST_SECOND)
	) else $error("ddr_write_burst: ST_FIRST not followed by ST_SECOND");

	// a registered oe must come from a burst state one edge earlier
	a_oe_in_burst: assert property (
		@(posedge clk) disable iff (!dr_reset_n)
		ctl_pair.rise.oe |-> ($past(state) inside {ST_FIRST, ST_SECOND})
	) else $error("ddr_write_burst: oe outside a burst");

endmodule

//--- rtl/ddio_out_soft.sv
/*
 * Soft DDR output cell built from core logic.
 * A rise/fall pair is registered on the rising edge of clk. The rise half
 * is driven while clk is high and the fall half while clk is low, so every
 * pin carries two beats per clock. Latency from pair_in to the pins is one
 * cycle. Instantiate one cell per group of pins that share a pair.
 */
`timescale 1ns/1ps

module ddio_out_soft
	import ddr_data_pkg::*;
#(
	// pins in the group, also the width of one beat
	parameter int DATA_WIDTH = 8
) (
	input  logic                             clk,
	input  logic                             dr_reset_n,
	// rise beat in the lower half, fall beat in the upper half
	input  logic [PAIR_BEATS*DATA_WIDTH-1:0] pair_in,
	output logic [DATA_WIDTH-1:0]            pin_out
);

	// ****************************************
	// pair capture
	// ****************************************

	// both beats of the current clock
	logic [PAIR_BEATS*DATA_WIDTH-1:0] pair_q;

	// cleared low so that the pins idle at 0
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			pair_q <= '0;
		end else begin
			pair_q <= pair_in;
		end
	end

	// ****************************************
	// phase multiplexer
	// ****************************************

	// per-bit select on the clock level
	// high phase gives the rise beat, low phase the fall beat
	for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_bit
		logic rise_bit;
		logic fall_bit;

		assign rise_bit = pair_q[i];
		// same bit position one beat up
		assign fall_bit = pair_q[DATA_WIDTH + i];

		assign pin_out[i] = clk ? rise_bit : fall_bit;
	end

	// ****************************************
	// checks
	// ****************************************

	// the driver of pair_in is a registered sequencer with reset
	// an X here would reach the pins for a whole clock
	a_pair_known: assert property (
		@(posedge clk) disable iff (!dr_reset_n)
		!$isunknown(pair_in)
	) else $error("ddio_out_soft: unknown bits on pair_in");

endmodule

//--- rtl/ddr_ctrl_pkg.sv
/*
 * Command and sequencer types of the DDR write path.
 * Used by the burst sequencer, by the top level and by the testbench stimulus.
 */
`include "ddr_out_config.svh"

package ddr_ctrl_pkg;

	// write opcodes
	// masked write drives dm from the mask, plain write keeps dm low
	typedef enum logic {
		OP_WRITE        = 1'b0,
		OP_WRITE_MASKED = 1'b1
	} wr_op_e;

	// burst sequencer states
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_FIRST  = 2'd1,
		ST_SECOND = 2'd2
	} burst_state_e;

	// one write command, beat k in data[k] and mask[k]
	typedef struct packed {
		wr_op_e                                        op;
		logic [`DDR_BURST_LEN-1:0][`DDR_DQ_WIDTH-1:0] data;
		logic [`DDR_BURST_LEN-1:0][`DDR_DM_WIDTH-1:0] mask;
	} wr_cmd_t;

endpackage

//--- rtl/ddr_data_pkg.sv
/*
 * Data-path types of the DDR write path.
 * A pair holds the two beats sent in one clock: rise in the high phase,
 * fall in the low phase. The rise field is the lower half of the vector.
 */
`include "ddr_out_config.svh"

package ddr_data_pkg;

	// beats carried by one pair, one per clock phase
	localparam int PAIR_BEATS = 2;

	// one data beat on dq
	typedef logic [`DDR_DQ_WIDTH-1:0] dq_beat_t;

	// one control beat, oe on top and dm at the bottom
	typedef struct packed {
		logic                     oe;
		logic                     dqs;
		logic [`DDR_DM_WIDTH-1:0] dm;
	} ctl_beat_t;

	localparam int CTL_WIDTH = $bits(ctl_beat_t);

	// fall is declared first so that rise lands in the low bits
	typedef struct packed {
		dq_beat_t fall;
		dq_beat_t rise;
	} dq_pair_t;

	typedef struct packed {
		ctl_beat_t fall;
		ctl_beat_t rise;
	} ctl_pair_t;

endpackage

//--- rtl/ddr_out_config.svh
/*
 * Build-time sizes for the DDR write data path.
 * Include this header wherever beat, mask or burst sizes are needed.
 */
`ifndef DDR_OUT_CONFIG_SVH
`define DDR_OUT_CONFIG_SVH

// ****************************************
// beat geometry
// ****************************************

// bits per data beat on the dq pins
`define DDR_DQ_WIDTH 8

// one mask bit per byte lane
`define DDR_DM_WIDTH 1

// beats per write burst, sent as two rise/fall pairs
`define DDR_BURST_LEN 4

`endif
